//--- verilog/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    // Data path widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;

    // Major opcodes handled by the core
    localparam opcode_t OPCODE_OP     = 7'b0110011;
    localparam opcode_t OPCODE_OP_IMM = 7'b0010011;
    localparam opcode_t OPCODE_LUI    = 7'b0110111;

    localparam int NUM_REGS = 32;

    // ALU operations with pass-b carrying the lui immediate through
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

endpackage

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu
    import rv32i_pkg::*;
(
    input  alu_op_t alu_op,
    input  word_t   operand_a,
    input  word_t   operand_b,
    output word_t   result
);

    logic [4:0] shamt;

    // Only the low five bits count for shifts
    assign shamt = operand_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                result = operand_a + operand_b;
            end
            ALU_SUB: begin
                result = operand_a - operand_b;
            end
            ALU_SLL: begin
                result = operand_a << shamt;
            end
            ALU_SLT: begin
                result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            end
            ALU_SLTU: begin
                result = {31'b0, operand_a < operand_b};
            end
            ALU_XOR: begin
                result = operand_a ^ operand_b;
            end
            ALU_SRL: begin
                result = operand_a >> shamt;
            end
            ALU_SRA: begin
                result = word_t'($signed(operand_a) >>> shamt);
            end
            ALU_OR: begin
                result = operand_a | operand_b;
            end
            ALU_AND: begin
                result = operand_a & operand_b;
            end
            ALU_PASS_B: begin
                result = operand_b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file
    import rv32i_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  logic      write_enable,
    input  reg_addr_t write_rd,
    input  word_t     write_data,
    output word_t     read_data1,
    output word_t     read_data2
);

    word_t regs [NUM_REGS];

    // x0 stays zero since no valid write ever targets it
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable) begin
            regs[write_rd] <= write_data;
        end
    end

    // Combinational read ports
    assign read_data1 = regs[rs1];
    assign read_data2 = regs[rs2];

endmodule

`default_nettype wire

//--- verilog/forward_unit.sv
`timescale 1ns/1ns
`default_nettype none

module forward_unit
    import rv32i_pkg::*;
(
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  logic      ex_valid,
    input  reg_addr_t ex_rd,
    input  word_t     ex_result,
    input  logic      wb_valid,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    input  word_t     read_data1,
    input  word_t     read_data2,
    output word_t     operand_a,
    output word_t     operand_b
);

    // Newest producer wins with execute ahead of write-back
    function automatic word_t pick(input reg_addr_t rs, input word_t rf_data);
        if (ex_valid && ex_rd == rs) begin
            return ex_result;
        end else if (wb_valid && wb_rd == rs) begin
            return wb_data;
        end
        return rf_data;
    endfunction

    always_comb begin
        operand_a = pick(rs1, read_data1);
        operand_b = pick(rs2, read_data2);
    end

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage
    import rv32i_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      instr_valid,
    input  instr_t    instr,
    input  word_t     ex_result,
    input  logic      wb_valid,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    output logic      ex_valid,
    output reg_addr_t ex_rd,
    output alu_op_t   ex_alu_op,
    output word_t     ex_operand_a,
    output word_t     ex_operand_b
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    word_t      imm_i;
    word_t      imm_shamt;
    word_t      imm_u;
    word_t      imm;
    alu_op_t    alu_op;
    logic       supported;
    logic       dec_valid;
    word_t      read_data1;
    word_t      read_data2;
    word_t      fwd_a;
    word_t      fwd_b;
    word_t      operand_b;

    // Shared by OP and OP-IMM; alt selects sub and sra
    function automatic alu_op_t funct_to_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000: return alt ? ALU_SUB : ALU_ADD;
            3'b001: return ALU_SLL;
            3'b010: return ALU_SLT;
            3'b011: return ALU_SLTU;
            3'b100: return ALU_XOR;
            3'b101: return alt ? ALU_SRA : ALU_SRL;
            3'b110: return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign imm_i     = {{20{instr[31]}}, instr[31:20]};
    assign imm_shamt = {27'b0, instr[24:20]};
    assign imm_u     = {instr[31:12], 12'b0};

    always_comb begin
        supported = 1'b0;
        alu_op    = ALU_ADD;
        imm       = imm_i;
        case (opcode)
            OPCODE_OP: begin
                supported = 1'b1;
                alu_op    = funct_to_op(funct3, funct7[5]);
            end
            OPCODE_OP_IMM: begin
                supported = 1'b1;
                // Bit 30 only means srai here, addi keeps it as immediate
                alu_op    = funct_to_op(funct3, funct3 == 3'b101 && funct7[5]);
                if (funct3[1:0] == 2'b01) begin
                    imm = imm_shamt;
                end
            end
            OPCODE_LUI: begin
                supported = 1'b1;
                alu_op    = ALU_PASS_B;
                imm       = imm_u;
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    // Writes to x0 are dropped right here
    assign dec_valid = supported && rd != '0;
    assign operand_b = (opcode == OPCODE_OP) ? fwd_b : imm;

    register_file u_register_file (
        .clk          (clk),
        .reset        (reset),
        .rs1          (rs1),
        .rs2          (rs2),
        .write_enable (wb_valid),
        .write_rd     (wb_rd),
        .write_data   (wb_data),
        .read_data1   (read_data1),
        .read_data2   (read_data2)
    );

    forward_unit u_forward_unit (
        .rs1        (rs1),
        .rs2        (rs2),
        .ex_valid   (ex_valid),
        .ex_rd      (ex_rd),
        .ex_result  (ex_result),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .read_data1 (read_data1),
        .read_data2 (read_data2),
        .operand_a  (fwd_a),
        .operand_b  (fwd_b)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= instr_valid && dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_rd        <= rd;
        ex_alu_op    <= alu_op;
        ex_operand_a <= fwd_a;
        ex_operand_b <= operand_b;
    end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage
    import rv32i_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      ex_valid,
    input  reg_addr_t ex_rd,
    input  alu_op_t   ex_alu_op,
    input  word_t     ex_operand_a,
    input  word_t     ex_operand_b,
    output word_t     ex_result,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);

    // Result also goes back to decode for forwarding
    alu u_alu (
        .alu_op    (ex_alu_op),
        .operand_a (ex_operand_a),
        .operand_b (ex_operand_b),
        .result    (ex_result)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= ex_rd;
        wb_data <= ex_result;
    end

endmodule

`default_nettype wire

//--- verilog/rv32i_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv32i_core
    import rv32i_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      instr_valid,
    input  instr_t    instr,
    output logic      retire_valid,
    output reg_addr_t retire_rd,
    output word_t     retire_data
);

    logic      ex_valid;
    reg_addr_t ex_rd;
    alu_op_t   ex_alu_op;
    word_t     ex_operand_a;
    word_t     ex_operand_b;
    word_t     ex_result;

    // Write-back fields double as the retire port
    decode_stage u_decode_stage (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .ex_result    (ex_result),
        .wb_valid     (retire_valid),
        .wb_rd        (retire_rd),
        .wb_data      (retire_data),
        .ex_valid     (ex_valid),
        .ex_rd        (ex_rd),
        .ex_alu_op    (ex_alu_op),
        .ex_operand_a (ex_operand_a),
        .ex_operand_b (ex_operand_b)
    );

    execute_stage u_execute_stage (
        .clk          (clk),
        .reset        (reset),
        .ex_valid     (ex_valid),
        .ex_rd        (ex_rd),
        .ex_alu_op    (ex_alu_op),
        .ex_operand_a (ex_operand_a),
        .ex_operand_b (ex_operand_b),
        .ex_result    (ex_result),
        .wb_valid     (retire_valid),
        .wb_rd        (retire_rd),
        .wb_data      (retire_data)
    );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

`default_nettype wire

//--- verification/tb_rv32i_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv32i_core
    import rv32i_pkg::*;
();

    localparam int MAX_ENTRIES  = 64;
    localparam int NUM_GROUPS   = 6;
    localparam int RESET_CYCLES = 10;

    logic      clk;
    logic      reset;
    logic      instr_valid;
    instr_t    instr;
    logic      retire_valid;
    reg_addr_t retire_rd;
    word_t     retire_data;

    instr_t    instr_tab  [MAX_ENTRIES];
    logic      retire_tab [MAX_ENTRIES];
    reg_addr_t rd_tab     [MAX_ENTRIES];
    word_t     data_tab   [MAX_ENTRIES];
    int        group_tab  [MAX_ENTRIES];
    string     group_name [1:NUM_GROUPS];
    int        num_entries = 0;

    // Entries in flight and the cycle each one must retire in
    int        pending_idx [$];
    int        pending_cycle [$];

    int        seed = 32'h81b6;
    int        cycle = 0;
    int        errors = 0;
    int        group_errors = 0;
    int        checks = 0;
    int        groups_failed = 0;
    logic      monitor_on = 1'b0;

    tb_clock_gen u_clock_gen (
        .clk (clk)
    );

    rv32i_core UUT (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic instr_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                      input reg_addr_t rd, input reg_addr_t rs1,
                                      input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OPCODE_OP};
    endfunction

    function automatic instr_t i_type(input logic [2:0] f3, input reg_addr_t rd,
                                      input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OPCODE_OP_IMM};
    endfunction

    function automatic instr_t u_type(input opcode_t op, input reg_addr_t rd,
                                      input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    task automatic add_entry(input int group, input instr_t word, input logic retires,
                             input reg_addr_t rd, input word_t data);
        instr_tab[num_entries]  = word;
        retire_tab[num_entries] = retires;
        rd_tab[num_entries]     = rd;
        data_tab[num_entries]   = data;
        group_tab[num_entries]  = group;
        num_entries++;
    endtask

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        checks++;
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            errors++;
            group_errors++;
        end
    endtask

    // Expected values worked out by hand from all-zero registers
    task automatic load_table();
        group_name[1] = "reset and first add";
        group_name[2] = "alu operations";
        group_name[3] = "lui";
        group_name[4] = "back-to-back forwarding";
        group_name[5] = "random bubbles";
        group_name[6] = "x0 and unsupported opcodes";
        add_entry(1, r_type(7'h00, 3'd0, 5'd1, 5'd0, 5'd0), 1'b1, 5'd1, 32'h0);
        add_entry(2, i_type(3'd0, 5'd2, 5'd0, 12'd100), 1'b1, 5'd2, 32'h00000064);
        add_entry(2, i_type(3'd0, 5'd3, 5'd0, 12'hff9), 1'b1, 5'd3, 32'hfffffff9);
        add_entry(2, i_type(3'd2, 5'd4, 5'd3, 12'd5), 1'b1, 5'd4, 32'h1);
        add_entry(2, i_type(3'd3, 5'd5, 5'd3, 12'd5), 1'b1, 5'd5, 32'h0);
        add_entry(2, i_type(3'd4, 5'd6, 5'd2, 12'h0f0), 1'b1, 5'd6, 32'h00000094);
        add_entry(2, i_type(3'd6, 5'd7, 5'd2, 12'h00c), 1'b1, 5'd7, 32'h0000006c);
        add_entry(2, i_type(3'd7, 5'd8, 5'd3, 12'h0ff), 1'b1, 5'd8, 32'h000000f9);
        add_entry(2, i_type(3'd1, 5'd9, 5'd2, 12'h004), 1'b1, 5'd9, 32'h00000640);
        add_entry(2, i_type(3'd5, 5'd10, 5'd3, 12'h01c), 1'b1, 5'd10, 32'h0000000f);
        add_entry(2, i_type(3'd5, 5'd11, 5'd3, 12'h401), 1'b1, 5'd11, 32'hfffffffc);
        add_entry(2, r_type(7'h00, 3'd0, 5'd12, 5'd2, 5'd3), 1'b1, 5'd12, 32'h0000005d);
        add_entry(2, r_type(7'h20, 3'd0, 5'd13, 5'd2, 5'd3), 1'b1, 5'd13, 32'h0000006b);
        // Shift by x6 = 0x94 uses only its low five bits
        add_entry(2, r_type(7'h00, 3'd1, 5'd14, 5'd4, 5'd6), 1'b1, 5'd14, 32'h00100000);
        add_entry(2, r_type(7'h00, 3'd2, 5'd15, 5'd3, 5'd2), 1'b1, 5'd15, 32'h1);
        add_entry(2, r_type(7'h00, 3'd3, 5'd16, 5'd3, 5'd2), 1'b1, 5'd16, 32'h0);
        add_entry(2, r_type(7'h00, 3'd4, 5'd17, 5'd2, 5'd3), 1'b1, 5'd17, 32'hffffff9d);
        add_entry(2, r_type(7'h00, 3'd5, 5'd18, 5'd3, 5'd4), 1'b1, 5'd18, 32'h7ffffffc);
        add_entry(2, r_type(7'h20, 3'd5, 5'd19, 5'd3, 5'd4), 1'b1, 5'd19, 32'hfffffffc);
        add_entry(2, r_type(7'h00, 3'd6, 5'd20, 5'd2, 5'd10), 1'b1, 5'd20, 32'h0000006f);
        add_entry(2, r_type(7'h00, 3'd7, 5'd21, 5'd3, 5'd2), 1'b1, 5'd21, 32'h00000060);
        add_entry(3, u_type(OPCODE_LUI, 5'd22, 20'h12345), 1'b1, 5'd22, 32'h12345000);
        add_entry(3, u_type(OPCODE_LUI, 5'd23, 20'hfffff), 1'b1, 5'd23, 32'hfffff000);
        add_entry(4, i_type(3'd0, 5'd24, 5'd0, 12'd1), 1'b1, 5'd24, 32'h1);
        add_entry(4, i_type(3'd0, 5'd24, 5'd24, 12'd3), 1'b1, 5'd24, 32'h4);
        add_entry(4, r_type(7'h00, 3'd0, 5'd25, 5'd24, 5'd24), 1'b1, 5'd25, 32'h8);
        add_entry(4, r_type(7'h20, 3'd0, 5'd26, 5'd25, 5'd24), 1'b1, 5'd26, 32'h4);
        add_entry(4, r_type(7'h00, 3'd0, 5'd27, 5'd24, 5'd25), 1'b1, 5'd27, 32'hc);
        add_entry(5, i_type(3'd0, 5'd28, 5'd0, 12'h7ff), 1'b1, 5'd28, 32'h000007ff);
        add_entry(5, i_type(3'd1, 5'd28, 5'd28, 12'h008), 1'b1, 5'd28, 32'h0007ff00);
        add_entry(5, i_type(3'd4, 5'd29, 5'd28, 12'hfff), 1'b1, 5'd29, 32'hfff800ff);
        add_entry(5, r_type(7'h00, 3'd0, 5'd30, 5'd29, 5'd28), 1'b1, 5'd30, 32'hffffffff);
        add_entry(6, i_type(3'd0, 5'd0, 5'd0, 12'd5), 1'b0, 5'd0, 32'h0);
        add_entry(6, r_type(7'h00, 3'd0, 5'd0, 5'd2, 5'd3), 1'b0, 5'd0, 32'h0);
        // sw x2, 4(x0) and auipc x5, 1
        add_entry(6, {7'h00, 5'd2, 5'd0, 3'd2, 5'd4, 7'b0100011}, 1'b0, 5'd0, 32'h0);
        add_entry(6, u_type(7'b0010111, 5'd5, 20'h00001), 1'b0, 5'd0, 32'h0);
        add_entry(6, r_type(7'h00, 3'd0, 5'd31, 5'd5, 5'd4), 1'b1, 5'd31, 32'h1);
        add_entry(6, r_type(7'h00, 3'd6, 5'd1, 5'd0, 5'd0), 1'b1, 5'd1, 32'h0);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr = $random(seed);
    endtask

    task automatic apply_entry(input int idx);
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instr = instr_tab[idx];
        if (retire_tab[idx]) begin
            pending_idx.push_back(idx);
            pending_cycle.push_back(cycle + 2);
        end
    endtask

    task automatic finish_group(input int g);
        idle_cycle();
        while (pending_idx.size() != 0) begin
            idle_cycle();
        end
        // Extra cycles catch late or stray retirements
        idle_cycle();
        idle_cycle();
        if (group_errors != 0) begin
            groups_failed++;
            $display("test %0d (%s): FAILED, %0d errors", g, group_name[g], group_errors);
        end else begin
            $display("test %0d (%s): ok, 0 errors", g, group_name[g]);
        end
        group_errors = 0;
    endtask

    always @(negedge clk) begin : retire_monitor
        int idx;
        int due;
        if (monitor_on && retire_valid) begin
            if (pending_idx.size() == 0) begin
                $display("error at %0t ns: x%0d retired while no instruction was expected",
                         $time, retire_rd);
                errors++;
                group_errors++;
            end else begin
                idx = pending_idx.pop_front();
                due = pending_cycle.pop_front();
                check_value({27'b0, retire_rd}, {27'b0, rd_tab[idx]},
                            $sformatf("entry %0d retire_rd", idx));
                check_value(retire_data, data_tab[idx], $sformatf("entry %0d retire_data", idx));
                check_value(cycle, due, $sformatf("entry %0d retire cycle", idx));
            end
        end
    end

    initial begin : watchdog
        int limit;
        #1;
        limit = RESET_CYCLES + 4 + 3 * num_entries + 2 + 8 * NUM_GROUPS;
        repeat (limit) @(posedge clk);
        $display("error: run did not finish within %0d cycles", limit);
        $display("Testbench failed");
        $finish;
    end

    initial begin : main
        int bubbles;
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        monitor_on = 1'b1;
        // Idle cycles right after reset must not retire anything
        repeat (4) idle_cycle();
        for (int i = 0; i < num_entries; i++) begin
            if (i > 0 && group_tab[i] != group_tab[i - 1]) begin
                finish_group(group_tab[i - 1]);
            end
            apply_entry(i);
            if (group_tab[i] != 4) begin
                bubbles = $unsigned($random(seed)) % 3;
                repeat (bubbles) idle_cycle();
            end
        end
        finish_group(group_tab[num_entries - 1]);
        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 NUM_GROUPS, groups_failed, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rv32i_core.f
verilog/rv32i_pkg.sv
verilog/alu.sv
verilog/register_file.sv
verilog/forward_unit.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/rv32i_core.sv
verification/tb_clock_gen.sv
verification/tb_rv32i_core.sv

//--- Makefile
TOP := tb_rv32i_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f rv32i_core.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
